// File: hw/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W      = 32;
    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);
    localparam int RAM_WORDS   = 256;
    localparam int RAM_AW      = $clog2(RAM_WORDS);
    // 16-byte lines, 16 line indices
    localparam int LINE_OFF_W  = 4;
    localparam int LINE_IDX_W  = 4;

    typedef enum logic [3:0] {
        NOP   = 4'd0,
        LD_B  = 4'd1,
        LD_BU = 4'd2,
        LD_H  = 4'd3,
        LD_HU = 4'd4,
        LD_W  = 4'd5,
        ST_B  = 4'd6,
        ST_H  = 4'd7,
        ST_W  = 4'd8,
        LL    = 4'd9,
        SC    = 4'd10
    } mem_op_e;

    typedef enum logic [2:0] {
        NONE = 3'd0,
        ADEM = 3'd1,
        TLBR = 3'd2,
        PIL  = 3'd3,
        PIS  = 3'd4,
        PPI  = 3'd5,
        PME  = 3'd6
    } ecode_e;

    typedef struct packed {
        logic [19:0] vppn;
        logic [19:0] ppn;
        logic        e;
        logic        v;
        logic        d;
        logic [1:0]  plv;
        logic [1:0]  mat;
    } tlb_entry_t;

    // Size encoding is 0 byte, 1 half, 2 word
    typedef struct packed {
        logic        load;
        logic        store;
        logic        ll;
        logic        sc;
        logic [1:0]  size;
        logic        sign;
        logic [3:0]  sel;
        logic [31:0] sdata;
        logic [1:0]  off;
    } dec_op_t;

endpackage

// File: hw/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
    import mem_pkg::*;

    logic              en;
    logic              we;
    logic [RAM_AW-1:0] word_addr;
    logic [3:0]        sel;
    logic [31:0]       wdata;
    logic [31:0]       rdata;

    modport master (
        output en, we, word_addr, sel, wdata,
        input  rdata
    );

    modport slave (
        input  en, we, word_addr, sel, wdata,
        output rdata
    );

endinterface

// File: hw/mem_op_decode.sv
`timescale 1ns/1ps

module mem_op_decode (
    input  mem_pkg::mem_op_e            op_i,
    input  logic [mem_pkg::ADDR_W-1:0]  vaddr_i,
    input  logic [31:0]                 wdata_i,
    output mem_pkg::dec_op_t            dec_o
);
    import mem_pkg::*;

    always_comb begin
        dec_o = '0;
        dec_o.off = vaddr_i[1:0];
        case (op_i)
            LD_B, LD_BU: begin
                dec_o.load = 1'b1;
                dec_o.sign = (op_i == LD_B);
                dec_o.size = 2'd0;
            end
            LD_H, LD_HU: begin
                dec_o.load = 1'b1;
                dec_o.sign = (op_i == LD_H);
                dec_o.size = 2'd1;
            end
            LD_W, LL: begin
                dec_o.load = 1'b1;
                dec_o.ll = (op_i == LL);
                dec_o.size = 2'd2;
            end
            ST_B: begin
                dec_o.store = 1'b1;
                dec_o.size = 2'd0;
            end
            ST_H: begin
                dec_o.store = 1'b1;
                dec_o.size = 2'd1;
            end
            ST_W, SC: begin
                dec_o.store = 1'b1;
                dec_o.sc = (op_i == SC);
                dec_o.size = 2'd2;
            end
            default: ;
        endcase

        // Byte lanes only for real accesses
        if (dec_o.load || dec_o.store) begin
            case (dec_o.size)
                2'd0: dec_o.sel = 4'b0001 << vaddr_i[1:0];
                2'd1: dec_o.sel = 4'b0011 << vaddr_i[1:0];
                default: dec_o.sel = 4'b1111;
            endcase
        end

        case (dec_o.size)
            2'd0: dec_o.sdata = {24'b0, wdata_i[7:0]} << {vaddr_i[1:0], 3'b000};
            2'd1: dec_o.sdata = {16'b0, wdata_i[15:0]} << {vaddr_i[1:0], 3'b000};
            default: dec_o.sdata = wdata_i;
        endcase
    end

endmodule

// File: hw/addr_translate.sv
`timescale 1ns/1ps

module addr_translate (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           tlb_we_i,
    input  logic [mem_pkg::TLB_IDX_W-1:0]  tlb_idx_i,
    input  logic [19:0]                    tlb_vppn_i,
    input  logic [19:0]                    tlb_ppn_i,
    input  logic                           tlb_e_i,
    input  logic                           tlb_v_i,
    input  logic                           tlb_d_i,
    input  logic [1:0]                     tlb_plv_i,
    input  logic [1:0]                     tlb_mat_i,
    input  logic [mem_pkg::ADDR_W-1:0]     vaddr_i,
    input  logic                           trans_en_i,
    input  logic [1:0]                     plv_i,
    input  mem_pkg::dec_op_t               dec_i,
    output logic [mem_pkg::ADDR_W-1:0]     paddr_o,
    output logic                           excp_o,
    output mem_pkg::ecode_e                ecode_o
);
    import mem_pkg::*;

    tlb_entry_t tlb [TLB_ENTRIES];
    tlb_entry_t wr_entry;
    tlb_entry_t hit_ent;
    logic       hit;
    logic       access;

    assign wr_entry = '{
        vppn: tlb_vppn_i,
        ppn:  tlb_ppn_i,
        e:    tlb_e_i,
        v:    tlb_v_i,
        d:    tlb_d_i,
        plv:  tlb_plv_i,
        mat:  tlb_mat_i
    };

    // Only the enable bits are cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                tlb[i].e <= 1'b0;
            end
        end else if (tlb_we_i) begin
            tlb[tlb_idx_i] <= wr_entry;
        end
    end

    // Fully associative match, lowest index wins
    always_comb begin
        hit = 1'b0;
        hit_ent = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit && tlb[i].e && (tlb[i].vppn == vaddr_i[ADDR_W-1:12])) begin
                hit = 1'b1;
                hit_ent = tlb[i];
            end
        end
    end

    assign paddr_o = trans_en_i ? {hit_ent.ppn, vaddr_i[11:0]} : vaddr_i;
    assign access = dec_i.load | dec_i.store;

    always_comb begin
        ecode_o = NONE;
        if (access && trans_en_i) begin
            if (plv_i == 2'd3 && vaddr_i[ADDR_W-1]) begin
                ecode_o = ADEM;
            end else if (!hit) begin
                ecode_o = TLBR;
            end else if (!hit_ent.v) begin
                ecode_o = dec_i.store ? PIS : PIL;
            end else if (plv_i > hit_ent.plv) begin
                ecode_o = PPI;
            end else if (dec_i.store && !hit_ent.d) begin
                ecode_o = PME;
            end
        end
    end

    assign excp_o = (ecode_o != NONE);

endmodule

// File: hw/mem1_stage.sv
`timescale 1ns/1ps

module mem1_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_i,
    input  logic [4:0]                  rd_i,
    input  mem_pkg::dec_op_t            dec_i,
    input  logic [mem_pkg::ADDR_W-1:0]  paddr_i,
    input  logic                        excp_i,
    input  mem_pkg::ecode_e             ecode_i,
    output logic                        ready_o,
    mem_req_if.master                   ram,
    output logic                        buf_valid_o,
    output logic                        buf_wreg_o,
    output logic [4:0]                  buf_waddr_o,
    output logic                        buf_sc_wdata_o,
    output logic                        buf_load_o,
    output logic [1:0]                  buf_size_o,
    output logic                        buf_sign_o,
    output logic [1:0]                  buf_off_o,
    output logic                        buf_excp_o,
    output mem_pkg::ecode_e             buf_ecode_o
);
    import mem_pkg::*;

    logic                  access;
    logic                  accept;
    logic                  sc_drop;
    logic                  link;
    logic [LINE_IDX_W-1:0] line_idx;
    logic                  last_st_valid;
    logic [LINE_IDX_W-1:0] last_st_idx;

    assign access = dec_i.load | dec_i.store;
    assign line_idx = paddr_i[LINE_OFF_W+LINE_IDX_W-1:LINE_OFF_W];

    // Hold off one cycle behind a store to the same line
    assign ready_o = ~(access & last_st_valid & (last_st_idx == line_idx));
    assign accept = issue_i & ready_o;

    // SC without the link bit writes nothing
    assign sc_drop = dec_i.sc & ~link;

    assign ram.en = accept & access & ~excp_i & ~sc_drop;
    assign ram.we = dec_i.store;
    assign ram.word_addr = paddr_i[RAM_AW+1:2];
    assign ram.sel = dec_i.sel;
    assign ram.wdata = dec_i.sdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_st_valid <= 1'b0;
            last_st_idx <= '0;
        end else begin
            last_st_valid <= ram.en & ram.we;
            last_st_idx <= line_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            link <= 1'b0;
        end else if (accept && !excp_i) begin
            if (dec_i.ll) begin
                link <= 1'b1;
            end else if (dec_i.sc) begin
                link <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid_o <= 1'b0;
        end else begin
            buf_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_wreg_o <= ~excp_i & (dec_i.load | dec_i.sc);
            buf_waddr_o <= rd_i;
            buf_sc_wdata_o <= link;
            buf_load_o <= dec_i.load;
            buf_size_o <= dec_i.size;
            buf_sign_o <= dec_i.sign;
            buf_off_o <= dec_i.off;
            buf_excp_o <= excp_i;
            buf_ecode_o <= ecode_i;
        end
    end

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input logic      clk,
    mem_req_if.slave ram
);
    import mem_pkg::*;

    logic [31:0] mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (ram.en) begin
            if (ram.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (ram.sel[b]) begin
                        mem[ram.word_addr][8*b +: 8] <= ram.wdata[8*b +: 8];
                    end
                end
            end
            // Old contents on a write, unused downstream
            ram.rdata <= mem[ram.word_addr];
        end
    end

endmodule

// File: hw/mem2_writeback.sv
`timescale 1ns/1ps

module mem2_writeback (
    input  logic            clk,
    input  logic            rst,
    input  logic            buf_valid_i,
    input  logic            buf_wreg_i,
    input  logic [4:0]      buf_waddr_i,
    input  logic            buf_sc_wdata_i,
    input  logic            buf_load_i,
    input  logic [1:0]      buf_size_i,
    input  logic            buf_sign_i,
    input  logic [1:0]      buf_off_i,
    input  logic            buf_excp_i,
    input  mem_pkg::ecode_e buf_ecode_i,
    input  logic [31:0]     rdata_i,
    output logic            res_valid_o,
    output logic            res_wreg_o,
    output logic [4:0]      res_waddr_o,
    output logic [31:0]     res_wdata_o,
    output logic            res_excp_o,
    output mem_pkg::ecode_e res_ecode_o
);

    logic [31:0] shifted;
    logic [31:0] ext;

    // Bring the addressed lane down to bit 0
    assign shifted = rdata_i >> {buf_off_i, 3'b000};

    always_comb begin
        case (buf_size_i)
            2'd0: ext = {{24{buf_sign_i & shifted[7]}}, shifted[7:0]};
            2'd1: ext = {{16{buf_sign_i & shifted[15]}}, shifted[15:0]};
            default: ext = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= buf_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        res_wreg_o <= buf_valid_i & buf_wreg_i;
        res_waddr_o <= buf_waddr_i;
        res_wdata_o <= buf_load_i ? ext : {31'b0, buf_sc_wdata_i};
        res_excp_o <= buf_excp_i;
        res_ecode_o <= buf_ecode_i;
    end

endmodule

// File: hw/mem_access_unit.sv
`timescale 1ns/1ps

module mem_access_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           issue_i,
    input  mem_pkg::mem_op_e               op_i,
    input  logic [mem_pkg::ADDR_W-1:0]     vaddr_i,
    input  logic [31:0]                    wdata_i,
    input  logic [4:0]                     rd_i,
    input  logic [1:0]                     plv_i,
    input  logic                           trans_en_i,
    input  logic                           tlb_we_i,
    input  logic [mem_pkg::TLB_IDX_W-1:0]  tlb_idx_i,
    input  logic [19:0]                    tlb_vppn_i,
    input  logic [19:0]                    tlb_ppn_i,
    input  logic                           tlb_e_i,
    input  logic                           tlb_v_i,
    input  logic                           tlb_d_i,
    input  logic [1:0]                     tlb_plv_i,
    input  logic [1:0]                     tlb_mat_i,
    output logic                           ready_o,
    output logic                           res_valid_o,
    output logic                           res_wreg_o,
    output logic [4:0]                     res_waddr_o,
    output logic [31:0]                    res_wdata_o,
    output logic                           res_excp_o,
    output mem_pkg::ecode_e                res_ecode_o
);
    import mem_pkg::*;

    dec_op_t            dec;
    logic [ADDR_W-1:0]  paddr;
    logic               excp;
    ecode_e             ecode;

    logic               buf_valid;
    logic               buf_wreg;
    logic [4:0]         buf_waddr;
    logic               buf_sc_wdata;
    logic               buf_load;
    logic [1:0]         buf_size;
    logic               buf_sign;
    logic [1:0]         buf_off;
    logic               buf_excp;
    ecode_e             buf_ecode;

    mem_req_if ram_bus ();

    mem_op_decode u_decode (
        .op_i    (op_i),
        .vaddr_i (vaddr_i),
        .wdata_i (wdata_i),
        .dec_o   (dec)
    );

    addr_translate u_translate (
        .clk        (clk),
        .rst        (rst),
        .tlb_we_i   (tlb_we_i),
        .tlb_idx_i  (tlb_idx_i),
        .tlb_vppn_i (tlb_vppn_i),
        .tlb_ppn_i  (tlb_ppn_i),
        .tlb_e_i    (tlb_e_i),
        .tlb_v_i    (tlb_v_i),
        .tlb_d_i    (tlb_d_i),
        .tlb_plv_i  (tlb_plv_i),
        .tlb_mat_i  (tlb_mat_i),
        .vaddr_i    (vaddr_i),
        .trans_en_i (trans_en_i),
        .plv_i      (plv_i),
        .dec_i      (dec),
        .paddr_o    (paddr),
        .excp_o     (excp),
        .ecode_o    (ecode)
    );

    mem1_stage u_mem1 (
        .clk            (clk),
        .rst            (rst),
        .issue_i        (issue_i),
        .rd_i           (rd_i),
        .dec_i          (dec),
        .paddr_i        (paddr),
        .excp_i         (excp),
        .ecode_i        (ecode),
        .ready_o        (ready_o),
        .ram            (ram_bus.master),
        .buf_valid_o    (buf_valid),
        .buf_wreg_o     (buf_wreg),
        .buf_waddr_o    (buf_waddr),
        .buf_sc_wdata_o (buf_sc_wdata),
        .buf_load_o     (buf_load),
        .buf_size_o     (buf_size),
        .buf_sign_o     (buf_sign),
        .buf_off_o      (buf_off),
        .buf_excp_o     (buf_excp),
        .buf_ecode_o    (buf_ecode)
    );

    data_ram u_ram (
        .clk (clk),
        .ram (ram_bus.slave)
    );

    mem2_writeback u_mem2 (
        .clk            (clk),
        .rst            (rst),
        .buf_valid_i    (buf_valid),
        .buf_wreg_i     (buf_wreg),
        .buf_waddr_i    (buf_waddr),
        .buf_sc_wdata_i (buf_sc_wdata),
        .buf_load_i     (buf_load),
        .buf_size_i     (buf_size),
        .buf_sign_i     (buf_sign),
        .buf_off_i      (buf_off),
        .buf_excp_i     (buf_excp),
        .buf_ecode_i    (buf_ecode),
        .rdata_i        (ram_bus.rdata),
        .res_valid_o    (res_valid_o),
        .res_wreg_o     (res_wreg_o),
        .res_waddr_o    (res_waddr_o),
        .res_wdata_o    (res_wdata_o),
        .res_excp_o     (res_excp_o),
        .res_ecode_o    (res_ecode_o)
    );

endmodule

// File: tb/mem_access_unit_props.sv
`timescale 1ns/1ps

module mem_access_unit_props (
    input logic clk_i,
    input logic rst_i,
    input logic issue_i,
    input logic ready_i,
    input logic excp_i,
    input logic res_valid_i,
    input logic res_wreg_i,
    input logic res_excp_i
);

    // Result two edges after the accepting edge
    latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_i && ready_i |-> ##2 res_valid_i)
        else $error("res_valid did not follow an acceptance two edges later");

    // A line stall never lasts more than one cycle
    stall_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !ready_i |=> ready_i)
        else $error("ready stayed low for more than one cycle");

    // Excepting access comes out flagged and writes no register
    excp_result_a: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_i && ready_i && excp_i |-> ##2 (res_excp_i && !res_wreg_i))
        else $error("excepting access did not come out flagged without a write");

    reset_a: assert property (@(posedge clk_i)
        rst_i |=> !res_valid_i)
        else $error("res_valid high right after reset");

endmodule

bind mem_access_unit mem_access_unit_props props (
    .clk_i       (clk),
    .rst_i       (rst),
    .issue_i     (issue_i),
    .ready_i     (ready_o),
    .excp_i      (excp),
    .res_valid_i (res_valid_o),
    .res_wreg_i  (res_wreg_o),
    .res_excp_i  (res_excp_o)
);

// File: tb/mem_access_unit_tb.sv
`timescale 1ns/1ps

module mem_access_unit_tb;
    import mem_pkg::*;

    localparam int HALF_PERIOD  = 10;
    localparam int SETTLE       = 5;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_WAIT     = 50;

    typedef struct packed {
        logic [255:0] name;
        logic [4:0]   rd;
        logic [7:0]   exp_stall;
        logic [7:0]   act_stall;
        logic         wreg;
        logic [31:0]  wdata;
        logic         excp;
        logic [2:0]   ecode;
    } expect_t;

    logic             clk = 1'b0;
    logic             rst;
    logic             issue_i;
    mem_op_e          op_i;
    logic [31:0]      vaddr_i;
    logic [31:0]      wdata_i;
    logic [4:0]       rd_i;
    logic [1:0]       plv_i;
    logic             trans_en_i;
    logic             tlb_we_i;
    logic [TLB_IDX_W-1:0] tlb_idx_i;
    logic [19:0]      tlb_vppn_i;
    logic [19:0]      tlb_ppn_i;
    logic             tlb_e_i;
    logic             tlb_v_i;
    logic             tlb_d_i;
    logic [1:0]       tlb_plv_i;
    logic [1:0]       tlb_mat_i;
    logic             ready_o;
    logic             res_valid_o;
    logic             res_wreg_o;
    logic [4:0]       res_waddr_o;
    logic [31:0]      res_wdata_o;
    logic             res_excp_o;
    ecode_e           res_ecode_o;

    expect_t          exp_q[$];
    int               passed;
    int               failed;
    logic             aborted;

    int               fd;
    int               r;
    logic             end_of_data;
    logic [255:0]     tag;
    logic [8*256-1:0] line;
    logic [31:0]      f_op, f_vaddr, f_wdata, f_rd, f_plv, f_trans, f_back;
    logic [31:0]      f_stall, f_wreg, f_res, f_excp, f_ecode;
    logic [31:0]      f_idx, f_vppn, f_ppn, f_e, f_v, f_d, f_tplv, f_mat;
    logic [255:0]     f_name;
    expect_t          e_new;

    mem_access_unit dut (.*);

    always #HALF_PERIOD clk = ~clk;

    task automatic check_result();
        expect_t e;
        logic ok;
        if (exp_q.size() == 0) begin
            $display("A result came out with no access outstanding");
            failed++;
        end else begin
            e = exp_q.pop_front();
            ok = 1'b1;
            if (e.act_stall != e.exp_stall) begin
                $display("ERROR %0s stall expected %0d actual %0d", e.name, e.exp_stall,
                         e.act_stall);
                ok = 1'b0;
            end
            if (res_wreg_o !== e.wreg) begin
                $display("ERROR %0s wreg expected %0d actual %0d", e.name, e.wreg, res_wreg_o);
                ok = 1'b0;
            end
            if (e.wreg && res_waddr_o !== e.rd) begin
                $display("ERROR %0s waddr expected %0d actual %0d", e.name, e.rd, res_waddr_o);
                ok = 1'b0;
            end
            if (e.wreg && res_wdata_o !== e.wdata) begin
                $display("ERROR %0s wdata expected %08h actual %08h", e.name, e.wdata,
                         res_wdata_o);
                ok = 1'b0;
            end
            if (res_excp_o !== e.excp) begin
                $display("ERROR %0s excp expected %0d actual %0d", e.name, e.excp, res_excp_o);
                ok = 1'b0;
            end
            if (res_ecode_o !== e.ecode) begin
                $display("ERROR %0s ecode expected %0d actual %0d", e.name, e.ecode,
                         res_ecode_o);
                ok = 1'b0;
            end
            if (ok) begin
                passed++;
                $display("PASS %0s", e.name);
            end else begin
                failed++;
                $display("FAIL %0s", e.name);
            end
        end
    endtask

    // Results are sampled half a cycle after the edge that registers them
    always @(negedge clk) begin
        if (!rst && res_valid_o) begin
            check_result();
        end
    end

    task automatic write_tlb();
        tlb_we_i = 1'b1;
        tlb_idx_i = f_idx[TLB_IDX_W-1:0];
        tlb_vppn_i = f_vppn[19:0];
        tlb_ppn_i = f_ppn[19:0];
        tlb_e_i = f_e[0];
        tlb_v_i = f_v[0];
        tlb_d_i = f_d[0];
        tlb_plv_i = f_tplv[1:0];
        tlb_mat_i = f_mat[1:0];
        @(negedge clk);
        tlb_we_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        logic done;
        waited = 0;
        done = 1'b0;
        while (!done && waited < MAX_WAIT) begin
            #SETTLE;
            done = (exp_q.size() == 0);
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("Timed out waiting for %0d outstanding results", exp_q.size());
            aborted = 1'b1;
        end
    endtask

    // Holds the access on the inputs until ready_o is seen high
    task automatic issue_access(input expect_t e);
        int waited;
        logic accepted;
        op_i = mem_op_e'(f_op[3:0]);
        vaddr_i = f_vaddr;
        wdata_i = f_wdata;
        rd_i = e.rd;
        plv_i = f_plv[1:0];
        trans_en_i = f_trans[0];
        issue_i = 1'b1;
        waited = 0;
        accepted = 1'b0;
        while (!accepted && waited < MAX_WAIT) begin
            #SETTLE;
            if (ready_o) begin
                accepted = 1'b1;
                e.act_stall = waited[7:0];
                exp_q.push_back(e);
            end
            @(negedge clk);
            waited++;
        end
        issue_i = 1'b0;
        if (!accepted) begin
            $display("Access %0s was never accepted, ready_o stayed low", e.name);
            aborted = 1'b1;
        end
    endtask

    initial begin
        rst = 1'b1;
        issue_i = 1'b0;
        op_i = NOP;
        vaddr_i = '0;
        wdata_i = '0;
        rd_i = '0;
        plv_i = '0;
        trans_en_i = 1'b0;
        tlb_we_i = 1'b0;
        tlb_idx_i = '0;
        tlb_vppn_i = '0;
        tlb_ppn_i = '0;
        tlb_e_i = 1'b0;
        tlb_v_i = 1'b0;
        tlb_d_i = 1'b0;
        tlb_plv_i = '0;
        tlb_mat_i = '0;
        passed = 0;
        failed = 0;
        aborted = 1'b0;
        end_of_data = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("tb/mem_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/mem_testdata.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !end_of_data) begin
            r = $fscanf(fd, "%s", tag);
            if (r != 1) begin
                end_of_data = 1'b1;
            end else if (tag == "#") begin
                r = $fgets(line, fd);
            end else if (tag == "T") begin
                r = $fscanf(fd, "%h %h %h %h %h %h %h %h", f_idx, f_vppn, f_ppn, f_e, f_v,
                            f_d, f_tplv, f_mat);
                if (r != 8) begin
                    $display("Incomplete TLB record in the test data");
                    aborted = 1'b1;
                end else begin
                    wait_drain();
                    write_tlb();
                end
            end else if (tag == "A") begin
                r = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h", f_name, f_op,
                            f_vaddr, f_wdata, f_rd, f_plv, f_trans, f_back, f_stall,
                            f_wreg, f_res, f_excp, f_ecode);
                if (r != 13) begin
                    $display("Incomplete access record in the test data");
                    aborted = 1'b1;
                end else begin
                    e_new = '{name: f_name, rd: f_rd[4:0], exp_stall: f_stall[7:0],
                              act_stall: 8'd0, wreg: f_wreg[0], wdata: f_res,
                              excp: f_excp[0], ecode: f_ecode[2:0]};
                    // Back-to-back accesses skip the drain
                    if (!f_back[0]) begin
                        wait_drain();
                    end
                    if (!aborted) begin
                        issue_access(e_new);
                    end
                end
            end else begin
                $display("Unknown record type %0s in the test data", tag);
                aborted = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!aborted) begin
            wait_drain();
        end

        $display("Tests: %0d passed, %0d failed", passed, failed);
        if (!aborted && failed == 0 && passed > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/mem_testdata.txt
# A name op vaddr wdata rd plv trans back stall wreg result excp ecode, all hex
# T idx vppn ppn e v d plv mat, all hex
A st_w     8 00000040 80c3a5f7 01 0 0 0 0 0 00000000 0 0
A st_h     7 00000042 0000fedc 01 0 0 0 0 0 00000000 0 0
A st_b     6 00000041 0000009b 01 0 0 0 0 0 00000000 0 0
A ld_b_neg 1 00000041 00000000 02 0 0 0 0 1 ffffff9b 0 0
A ld_b_low 1 00000040 00000000 03 0 0 0 0 1 fffffff7 0 0
A ld_bu    2 00000040 00000000 04 0 0 0 0 1 000000f7 0 0
A ld_h     3 00000042 00000000 05 0 0 0 0 1 fffffedc 0 0
A ld_h_low 3 00000040 00000000 06 0 0 0 0 1 ffff9bf7 0 0
A ld_hu    4 00000042 00000000 07 0 0 0 0 1 0000fedc 0 0
A ld_w     5 00000040 00000000 08 0 0 0 0 1 fedc9bf7 0 0
A nop      0 00000000 00000000 00 0 0 0 0 0 00000000 0 0
T 0 00012 00000 1 1 1 3 1
T 1 00020 00000 1 0 1 3 0
T 2 00030 00000 1 1 1 0 0
T 3 00040 00000 1 1 0 3 0
A tlb_ld   5 00012040 00000000 09 0 1 0 0 1 fedc9bf7 0 0
A tlb_st   8 00012080 13579bdf 00 0 1 0 0 0 00000000 0 0
A alias_ld 5 00000080 00000000 0a 0 0 0 0 1 13579bdf 0 0
A pre_exc  8 00000100 11111111 00 0 0 0 0 0 00000000 0 0
A adem     8 80000100 deadbeef 00 3 1 0 0 0 00000000 1 1
A tlbr     8 00099100 deadbeef 00 0 1 0 0 0 00000000 1 2
A pil      5 00020100 00000000 0b 0 1 0 0 0 00000000 1 3
A pis      8 00020100 deadbeef 00 0 1 0 0 0 00000000 1 4
A ppi      8 00030100 deadbeef 00 1 1 0 0 0 00000000 1 5
A pme      8 00040100 deadbeef 00 0 1 0 0 0 00000000 1 6
A pme_ld   5 00040100 00000000 0c 0 1 0 0 1 11111111 0 0
A exc_rdbk 5 00000100 00000000 0d 0 0 0 0 1 11111111 0 0
A ll_pre   8 00000200 aaaa0001 00 0 0 0 0 0 00000000 0 0
A ll       9 00000200 00000000 0e 0 0 0 0 1 aaaa0001 0 0
A sc_ok    a 00000200 5555000a 0f 0 0 0 0 1 00000001 0 0
A sc_rdbk  5 00000200 00000000 10 0 0 0 0 1 5555000a 0 0
A sc_fail  a 00000200 77777777 11 0 0 0 0 1 00000000 0 0
A sc_keep  5 00000200 00000000 12 0 0 0 0 1 5555000a 0 0
A hz_st    8 00000300 cafef00d 00 0 0 0 0 0 00000000 0 0
A hz_ld    5 00000300 00000000 13 0 0 1 1 1 cafef00d 0 0
A nh_st    8 00000310 0badc0de 00 0 0 0 0 0 00000000 0 0
A nh_ld    5 00000300 00000000 14 0 0 1 0 1 cafef00d 0 0
A nh_rdbk  5 00000310 00000000 15 0 0 0 0 1 0badc0de 0 0

// File: mem_access_unit.f
hw/mem_pkg.sv
hw/mem_req_if.sv
hw/mem_op_decode.sv
hw/addr_translate.sv
hw/mem1_stage.sv
hw/data_ram.sv
hw/mem2_writeback.sv
hw/mem_access_unit.sv
tb/mem_access_unit_props.sv
tb/mem_access_unit_tb.sv

// File: Bender.yml
package:
  name: mem_access_unit

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/mem_req_if.sv
      - hw/mem_op_decode.sv
      - hw/addr_translate.sv
      - hw/mem1_stage.sv
      - hw/data_ram.sv
      - hw/mem2_writeback.sv
      - hw/mem_access_unit.sv
  - target: test
    files:
      - tb/mem_access_unit_props.sv
      - tb/mem_access_unit_tb.sv
